// ==== source/cam_video_pkg.sv ====
package cam_video_pkg;

    ////////////////////
    // bus and pixel types
    ////////////////////
    typedef logic [7:0]  cam_byte_t;   // one camera bus byte
    typedef logic [15:0] rgb565_t;     // camera order {b5, g6, r5}
    typedef logic [7:0]  colour8_t;    // one output channel

    // line phase of the display timing
    typedef enum logic [1:0]
    {
        TS_ACTIVE      = 2'd0,         // visible pixels
        TS_FRONT_BLANK = 2'd1,
        TS_SYNC        = 2'd2,         // hs asserted
        TS_BACK_BLANK  = 2'd3
    } timing_state_t;

    ////////////////////
    // 720p defaults
    ////////////////////
    localparam int DEF_H_ACTIVE = 1280;
    localparam int DEF_H_FRONT  = 110;
    localparam int DEF_H_SYNC   = 40;
    localparam int DEF_H_BACK   = 220;
    localparam int DEF_V_ACTIVE = 720;
    localparam int DEF_V_FRONT  = 5;
    localparam int DEF_V_SYNC   = 5;
    localparam int DEF_V_BACK   = 20;

    localparam int DEF_FIFO_DEPTH       = 2048;       // pixels
    localparam int DEF_STARTUP_CYCLES   = 10000;      // power-on hold
    localparam int DEF_HEARTBEAT_CYCLES = 33000000;   // half period

endpackage

// ==== source/cam_byte_packer.sv ====
module cam_byte_packer
(
    input  logic                     core_clk,
    input  logic                     arst_n_i,
    input  cam_video_pkg::cam_byte_t cam_data_i,     // changes on falling edge
    input  logic                     cam_href_i,
    input  logic                     cam_vsync_i,
    input  logic                     pix_ready_i,
    output logic                     pix_valid_o,
    output cam_video_pkg::rgb565_t   pix_data_o,
    output logic                     overflow_o
);

    cam_video_pkg::cam_byte_t data_q;     // registered camera byte
    cam_video_pkg::cam_byte_t hi_byte_q;  // waiting for its partner
    logic                     href_q;
    logic                     vsync_q;
    logic                     phase_q;    // 1 = high byte held

    ////////////////////
    // input register
    ////////////////////
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end
        else
        begin
            href_q  <= cam_href_i;
            vsync_q <= cam_vsync_i;
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_q <= cam_data_i;
    end

    ////////////////////
    // byte pairing
    ////////////////////
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            phase_q     <= 1'b0;
            pix_valid_o <= 1'b0;
        end
        else
        begin
            pix_valid_o <= 1'b0;                               // single-cycle strobe
            if (vsync_q || !href_q)
                phase_q <= 1'b0;                               // realign on blanking
            else if (!phase_q)
                phase_q <= 1'b1;                               // high byte taken
            else
            begin
                phase_q     <= 1'b0;
                pix_valid_o <= 1'b1;                           // word complete
            end
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (href_q && !vsync_q)
        begin
            if (!phase_q)
                hi_byte_q <= data_q;                           // high byte first
            else
                pix_data_o <= {hi_byte_q, data_q};
        end
    end

    // camera can't stall so a refused word is lost
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            overflow_o <= 1'b0;
        else if (pix_valid_o && !pix_ready_i)
            overflow_o <= 1'b1;                                // sticky until reset
    end

endmodule

// ==== source/pixel_fifo.sv ====
module pixel_fifo
#(
    parameter int DEPTH = cam_video_pkg::DEF_FIFO_DEPTH
)
(
    input  logic                   core_clk,
    input  logic                   arst_n_i,
    input  logic                   in_valid_i,
    input  cam_video_pkg::rgb565_t in_data_i,
    output logic                   in_ready_o,
    input  logic                   out_ready_i,
    output logic                   out_valid_o,
    output cam_video_pkg::rgb565_t out_data_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // pointer width
    localparam int CW = $clog2(DEPTH + 1);                 // fill width

    cam_video_pkg::rgb565_t mem [DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [CW-1:0]          fill;          // words in ram plus read port
    logic                   push;
    logic                   pop;
    logic                   mem_empty;
    logic                   load;          // move ram head to read port

    assign in_ready_o = (fill < CW'(DEPTH));
    assign push       = in_valid_i && in_ready_o;
    assign pop        = out_valid_o && out_ready_i;
    assign mem_empty  = (fill == CW'(out_valid_o));        // only the read port holds data
    assign load       = !mem_empty && (!out_valid_o || pop);

    always_ff @(posedge core_clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data_i;
        if (load)
            out_data_o <= mem[rd_ptr];                     // show-ahead register
    end

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            out_valid_o <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (load)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;                     // idle or both
            endcase
            if (load)
                out_valid_o <= 1'b1;
            else if (pop)
                out_valid_o <= 1'b0;                       // drained
        end
    end

endmodule

// ==== source/video_timing_gen.sv ====
module video_timing_gen
#(
    parameter int H_ACTIVE = cam_video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = cam_video_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = cam_video_pkg::DEF_H_SYNC,
    parameter int H_BACK   = cam_video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = cam_video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = cam_video_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = cam_video_pkg::DEF_V_SYNC,
    parameter int V_BACK   = cam_video_pkg::DEF_V_BACK
)
(
    input  logic core_clk,
    input  logic arst_n_i,
    input  logic enable_i,
    output logic active_req_o,
    output logic hs_o,
    output logic vs_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    cam_video_pkg::timing_state_t h_state;
    logic [HW-1:0]                h_cnt;       // position inside the phase
    logic [HW-1:0]                h_last;
    logic [VW-1:0]                v_cnt;       // line number
    logic                         run_q;
    logic                         line_end;

    always_comb
    begin
        case (h_state)
            cam_video_pkg::TS_ACTIVE:      h_last = HW'(H_ACTIVE - 1);
            cam_video_pkg::TS_FRONT_BLANK: h_last = HW'(H_FRONT - 1);
            cam_video_pkg::TS_SYNC:        h_last = HW'(H_SYNC - 1);
            default:                       h_last = HW'(H_BACK - 1);
        endcase
    end

    assign line_end = (h_state == cam_video_pkg::TS_BACK_BLANK) && (h_cnt == h_last);

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            run_q   <= 1'b0;
            h_state <= cam_video_pkg::TS_ACTIVE;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end
        else if (!enable_i)
        begin
            run_q   <= 1'b0;                                   // parked at line 0, pixel 0
            h_state <= cam_video_pkg::TS_ACTIVE;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end
        else
        begin
            run_q <= 1'b1;
            if (run_q)
            begin
                if (h_cnt == h_last)
                begin
                    h_cnt <= '0;
                    case (h_state)                             // next phase
                        cam_video_pkg::TS_ACTIVE:      h_state <= cam_video_pkg::TS_FRONT_BLANK;
                        cam_video_pkg::TS_FRONT_BLANK: h_state <= cam_video_pkg::TS_SYNC;
                        cam_video_pkg::TS_SYNC:        h_state <= cam_video_pkg::TS_BACK_BLANK;
                        default:                       h_state <= cam_video_pkg::TS_ACTIVE;
                    endcase
                end
                else
                    h_cnt <= h_cnt + 1'b1;
                if (line_end)
                    v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
            end
        end
    end

    assign active_req_o = run_q && (h_state == cam_video_pkg::TS_ACTIVE)
                          && (v_cnt < VW'(V_ACTIVE));
    assign hs_o         = run_q && (h_state == cam_video_pkg::TS_SYNC);
    assign vs_o         = run_q && (v_cnt >= VW'(V_ACTIVE + V_FRONT))
                          && (v_cnt < VW'(V_ACTIVE + V_FRONT + V_SYNC));

endmodule

// ==== source/rgb_out_stage.sv ====
module rgb_out_stage
(
    input  logic                    core_clk,
    input  logic                    arst_n_i,
    input  logic                    active_i,       // also the fifo pop request
    input  logic                    hs_i,
    input  logic                    vs_i,
    input  logic                    pix_valid_i,
    input  cam_video_pkg::rgb565_t  pix_data_i,     // camera order {b, g, r}
    output logic                    de_o,
    output logic                    hs_o,
    output logic                    vs_o,
    output cam_video_pkg::colour8_t r_o,
    output cam_video_pkg::colour8_t g_o,
    output cam_video_pkg::colour8_t b_o
);

    logic show_pix;                                  // pixel present at an active slot

    assign show_pix = active_i && pix_valid_i;

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            de_o <= 1'b0;
            hs_o <= 1'b0;
            vs_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end
        else
        begin
            de_o <= active_i;                        // one cycle behind the timing
            hs_o <= hs_i;
            vs_o <= vs_i;
            r_o  <= show_pix ? {pix_data_i[4:0], 3'b000} : '0;     // low field is red
            g_o  <= show_pix ? {pix_data_i[10:5], 2'b00} : '0;
            b_o  <= show_pix ? {pix_data_i[15:11], 3'b000} : '0;   // black on underrun
        end
    end

endmodule

// ==== source/startup_ctrl.sv ====
module startup_ctrl
#(
    parameter int STARTUP_CYCLES   = cam_video_pkg::DEF_STARTUP_CYCLES,
    parameter int HEARTBEAT_CYCLES = cam_video_pkg::DEF_HEARTBEAT_CYCLES
)
(
    input  logic core_clk,
    input  logic arst_n_i,
    output logic startup_done_o,
    output logic heartbeat_o
);

    localparam int SW = $clog2(STARTUP_CYCLES + 1);
    localparam int BW = (HEARTBEAT_CYCLES > 1) ? $clog2(HEARTBEAT_CYCLES) : 1;

    logic [SW-1:0] delay_cnt;     // edges since reset release
    logic [BW-1:0] beat_cnt;
    logic          beat_tc;       // half period reached

    ////////////////////
    // power-on delay
    ////////////////////
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            delay_cnt <= '0;
        else if (!startup_done_o)
            delay_cnt <= delay_cnt + 1'b1;                     // saturates at the limit
    end

    assign startup_done_o = (delay_cnt == SW'(STARTUP_CYCLES));

    ////////////////////
    // heartbeat
    ////////////////////
    assign beat_tc = (beat_cnt == BW'(HEARTBEAT_CYCLES - 1));

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            beat_cnt    <= '0;
            heartbeat_o <= 1'b1;                               // lit while held back
        end
        else if (startup_done_o)
        begin
            beat_cnt <= beat_tc ? '0 : beat_cnt + 1'b1;
            if (beat_tc)
                heartbeat_o <= ~heartbeat_o;
        end
    end

endmodule

// ==== source/cam_hdmi_top.sv ====
module cam_hdmi_top
#(
    parameter int H_ACTIVE         = cam_video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT          = cam_video_pkg::DEF_H_FRONT,
    parameter int H_SYNC           = cam_video_pkg::DEF_H_SYNC,
    parameter int H_BACK           = cam_video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE         = cam_video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT          = cam_video_pkg::DEF_V_FRONT,
    parameter int V_SYNC           = cam_video_pkg::DEF_V_SYNC,
    parameter int V_BACK           = cam_video_pkg::DEF_V_BACK,
    parameter int FIFO_DEPTH       = cam_video_pkg::DEF_FIFO_DEPTH,
    parameter int STARTUP_CYCLES   = cam_video_pkg::DEF_STARTUP_CYCLES,
    parameter int HEARTBEAT_CYCLES = cam_video_pkg::DEF_HEARTBEAT_CYCLES
)
(
    input  logic                     core_clk,
    input  logic                     arst_n_i,
    input  cam_video_pkg::cam_byte_t cam_data_i,
    input  logic                     cam_href_i,
    input  logic                     cam_vsync_i,
    output logic                     de_o,
    output logic                     hs_o,
    output logic                     vs_o,
    output cam_video_pkg::colour8_t  r_o,
    output cam_video_pkg::colour8_t  g_o,
    output cam_video_pkg::colour8_t  b_o,
    output logic                     startup_done_o,
    output logic                     overflow_o,
    output logic                     heartbeat_o
);

    logic                   pix_valid;     // packer to fifo
    logic                   pix_ready;
    cam_video_pkg::rgb565_t pix_data;
    logic                   out_valid;     // fifo to output stage
    cam_video_pkg::rgb565_t out_data;
    logic                   active_req;    // display pop request
    logic                   hs_raw;
    logic                   vs_raw;
    logic                   video_en;

    ////////////////////
    // capture side
    ////////////////////
    cam_byte_packer u_cam_byte_packer (
        .core_clk    (core_clk),
        .arst_n_i    (arst_n_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .pix_ready_i (pix_ready),
        .pix_valid_o (pix_valid),
        .pix_data_o  (pix_data),
        .overflow_o  (overflow_o)
    );

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) u_pixel_fifo (
        .core_clk    (core_clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (pix_valid),
        .in_data_i   (pix_data),
        .in_ready_o  (pix_ready),
        .out_ready_i (active_req),       // pop only in active slots
        .out_valid_o (out_valid),
        .out_data_o  (out_data)
    );

    ////////////////////
    // display side
    ////////////////////
    video_timing_gen #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_video_timing_gen (
        .core_clk     (core_clk),
        .arst_n_i     (arst_n_i),
        .enable_i     (video_en),
        .active_req_o (active_req),
        .hs_o         (hs_raw),
        .vs_o         (vs_raw)
    );

    rgb_out_stage u_rgb_out_stage (
        .core_clk    (core_clk),
        .arst_n_i    (arst_n_i),
        .active_i    (active_req),
        .hs_i        (hs_raw),
        .vs_i        (vs_raw),
        .pix_valid_i (out_valid),
        .pix_data_i  (out_data),
        .de_o        (de_o),
        .hs_o        (hs_o),
        .vs_o        (vs_o),
        .r_o         (r_o),
        .g_o         (g_o),
        .b_o         (b_o)
    );

    startup_ctrl #(
        .STARTUP_CYCLES   (STARTUP_CYCLES),
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) u_startup_ctrl (
        .core_clk       (core_clk),
        .arst_n_i       (arst_n_i),
        .startup_done_o (video_en),
        .heartbeat_o    (heartbeat_o)
    );

    assign startup_done_o = video_en;   // display release seen outside

endmodule

// ==== verif/tb_cam_hdmi_top.sv ====
module tb_cam_hdmi_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACT        = 8;
    localparam int LINE_CYCLES  = 14;       // 8 + 2 + 2 + 2
    localparam int FRAME_CYCLES = 98;       // 7 lines
    localparam int ACT_LINES    = 4;
    localparam int TOTAL_LINES  = 7;
    localparam int VS_CYCLES    = 14;       // one whole line
    localparam int STARTUP      = 200;
    localparam int HALF_BEAT    = 50;
    localparam int PAIRS        = 20;       // table size
    localparam int WAIT_LIMIT   = 500;      // cycles per wait loop

    logic                     core_clk = 1'b0;
    logic                     arst_n_i;
    cam_video_pkg::cam_byte_t cam_data_i;
    logic                     cam_href_i;
    logic                     cam_vsync_i;
    logic                     de_o;
    logic                     hs_o;
    logic                     vs_o;
    cam_video_pkg::colour8_t  r_o;
    cam_video_pkg::colour8_t  g_o;
    cam_video_pkg::colour8_t  b_o;
    logic                     startup_done_o;
    logic                     overflow_o;
    logic                     heartbeat_o;

    cam_video_pkg::cam_byte_t hi_tab [PAIRS];     // high byte sent first
    cam_video_pkg::cam_byte_t lo_tab [PAIRS];
    cam_video_pkg::colour8_t  exp_r [PAIRS];
    cam_video_pkg::colour8_t  exp_g [PAIRS];
    cam_video_pkg::colour8_t  exp_b [PAIRS];
    logic [31:0]              lcg_state;
    int                       cycle_cnt;          // edges since reset release
    int                       value_errs = 0;
    int                       other_errs = 0;

    always #2 core_clk = ~core_clk;               // 4 ns period

    always @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            cycle_cnt <= 0;
        else
            cycle_cnt <= cycle_cnt + 1;
    end

    cam_hdmi_top #(
        .H_ACTIVE (8), .H_FRONT (2), .H_SYNC (2), .H_BACK (2),
        .V_ACTIVE (4), .V_FRONT (1), .V_SYNC (1), .V_BACK (1),
        .FIFO_DEPTH (16), .STARTUP_CYCLES (STARTUP), .HEARTBEAT_CYCLES (HALF_BEAT)
    ) u_cam_hdmi_top (
        .core_clk       (core_clk),
        .arst_n_i       (arst_n_i),
        .cam_data_i     (cam_data_i),
        .cam_href_i     (cam_href_i),
        .cam_vsync_i    (cam_vsync_i),
        .de_o           (de_o),
        .hs_o           (hs_o),
        .vs_o           (vs_o),
        .r_o            (r_o),
        .g_o            (g_o),
        .b_o            (b_o),
        .startup_done_o (startup_done_o),
        .overflow_o     (overflow_o),
        .heartbeat_o    (heartbeat_o)
    );

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;            // classic lcg constants
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
        value_errs++;
    endtask

    // random byte pairs and the colours they should turn into
    task automatic build_table();
        lcg_state = 32'd38;                               // seed
        for (int i = 0; i < PAIRS; i++)
        begin
            lcg_state = lcg_step(lcg_state);
            hi_tab[i] = lcg_state[23:16];
            lcg_state = lcg_step(lcg_state);
            lo_tab[i] = lcg_state[23:16];
            exp_r[i]  = {lo_tab[i][4:0], 3'b000};                   // red in the low byte
            exp_g[i]  = {hi_tab[i][2:0], lo_tab[i][7:5], 2'b00};    // green straddles both
            exp_b[i]  = {hi_tab[i][7:3], 3'b000};                   // blue on top
        end
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (3) @(negedge core_clk);
        arst_n_i = 1'b1;                                  // released on a falling edge
    endtask

    task automatic check_reset_values(input string name);
        if (de_o !== 1'b0) report_mismatch({name, " de_o"}, 0, de_o);
        if (hs_o !== 1'b0) report_mismatch({name, " hs_o"}, 0, hs_o);
        if (vs_o !== 1'b0) report_mismatch({name, " vs_o"}, 0, vs_o);
        if ({r_o, g_o, b_o} !== 24'h0) report_mismatch({name, " colour"}, 0, {r_o, g_o, b_o});
        if (overflow_o !== 1'b0) report_mismatch({name, " overflow_o"}, 0, overflow_o);
        if (startup_done_o !== 1'b0) report_mismatch({name, " startup_done_o"}, 0, startup_done_o);
        if (heartbeat_o !== 1'b1) report_mismatch({name, " heartbeat_o"}, 1, heartbeat_o);
    endtask

    // vsync pulse followed by n pairs with href high
    task automatic drive_pairs(input int n);
        @(negedge core_clk);
        cam_vsync_i = 1'b1;
        repeat (2) @(negedge core_clk);
        cam_vsync_i = 1'b0;
        repeat (2) @(negedge core_clk);
        for (int i = 0; i < n; i++)
        begin
            cam_href_i = 1'b1;
            cam_data_i = hi_tab[i];
            @(negedge core_clk);
            cam_data_i = lo_tab[i];
            @(negedge core_clk);
        end
        cam_href_i = 1'b0;
        cam_data_i = '0;
        repeat (4) @(negedge core_clk);                   // let the last word land
    endtask

    task automatic wait_startup(input string name);
        int wait_cnt;
        wait_cnt = 0;
        while (!startup_done_o && wait_cnt < WAIT_LIMIT)
        begin
            @(negedge core_clk);
            wait_cnt++;
        end
        if (!startup_done_o)
        begin
            $display("timeout waiting for startup_done_o in %s", name);
            other_errs++;
        end
        else if (cycle_cnt != STARTUP)
            report_mismatch(name, STARTUP, cycle_cnt);
    endtask

    // one frame from the first de_o with n_pix real pixels and then blanks
    task automatic capture_frame(input string name, input int n_pix);
        int   wait_cnt;
        int   c;
        int   pix_idx;
        int   de_run;
        int   de_lines;
        int   hs_run;
        int   hs_pulses;
        int   hs_last;
        int   vs_cnt;
        logic de_prev;
        logic hs_prev;
        wait_cnt = 0;
        while (!de_o && wait_cnt < WAIT_LIMIT)
        begin
            @(negedge core_clk);
            wait_cnt++;
        end
        if (!de_o)
        begin
            $display("timeout waiting for de_o in %s", name);
            other_errs++;
            return;
        end
        pix_idx   = 0;
        de_run    = 0;
        de_lines  = 0;
        hs_run    = 0;
        hs_pulses = 0;
        hs_last   = -1;
        vs_cnt    = 0;
        de_prev   = 1'b0;
        hs_prev   = 1'b0;
        for (c = 0; c < FRAME_CYCLES; c++)
        begin
            if (de_o)
            begin
                if (pix_idx < n_pix)
                begin
                    if (r_o !== exp_r[pix_idx])
                        report_mismatch({name, " red"}, exp_r[pix_idx], r_o);
                    if (g_o !== exp_g[pix_idx])
                        report_mismatch({name, " green"}, exp_g[pix_idx], g_o);
                    if (b_o !== exp_b[pix_idx])
                        report_mismatch({name, " blue"}, exp_b[pix_idx], b_o);
                end
                else if ({r_o, g_o, b_o} !== 24'h0)
                    report_mismatch({name, " underrun colour"}, 0, {r_o, g_o, b_o});
                pix_idx++;
                de_run++;
            end
            else if (de_prev)
            begin
                if (de_run != H_ACT) report_mismatch({name, " de run"}, H_ACT, de_run);
                de_lines++;                                // one active line done
                de_run = 0;
            end
            if (hs_o && !hs_prev)
            begin
                if (hs_last >= 0 && c - hs_last != LINE_CYCLES)
                    report_mismatch({name, " hs period"}, LINE_CYCLES, c - hs_last);
                hs_last = c;
                hs_pulses++;
            end
            if (hs_o)
                hs_run++;
            else if (hs_prev)
            begin
                if (hs_run != 2) report_mismatch({name, " hs width"}, 2, hs_run);
                hs_run = 0;
            end
            if (vs_o)
                vs_cnt++;
            de_prev = de_o;
            hs_prev = hs_o;
            @(negedge core_clk);
        end
        if (de_lines != ACT_LINES) report_mismatch({name, " active lines"}, ACT_LINES, de_lines);
        if (hs_pulses != TOTAL_LINES)
            report_mismatch({name, " hs pulses"}, TOTAL_LINES, hs_pulses);
        if (vs_cnt != VS_CYCLES) report_mismatch({name, " vs cycles"}, VS_CYCLES, vs_cnt);
    endtask

    task automatic measure_heartbeat();
        int   wait_cnt;
        int   last_toggle;
        logic level;
        last_toggle = 0;
        for (int k = 0; k < 3; k++)
        begin
            level    = heartbeat_o;
            wait_cnt = 0;
            while (heartbeat_o === level && wait_cnt < WAIT_LIMIT)
            begin
                @(negedge core_clk);
                wait_cnt++;
            end
            if (heartbeat_o === level)
            begin
                $display("timeout waiting for a heartbeat toggle");
                other_errs++;
                return;
            end
            if (k > 0 && cycle_cnt - last_toggle != HALF_BEAT)
                report_mismatch("heartbeat half period", HALF_BEAT, cycle_cnt - last_toggle);
            last_toggle = cycle_cnt;
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial
    begin
        arst_n_i    = 1'b0;
        cam_data_i  = '0;
        cam_href_i  = 1'b0;
        cam_vsync_i = 1'b0;
        build_table();

        apply_reset();
        check_reset_values("reset values");
        drive_pairs(16);                                  // fills the fifo exactly
        if (overflow_o !== 1'b0) report_mismatch("pixel path overflow", 0, overflow_o);
        wait_startup("startup delay");
        capture_frame("pixel path", 16);                  // lines 3 and 4 underrun
        if (overflow_o !== 1'b0) report_mismatch("pixel path overflow end", 0, overflow_o);
        measure_heartbeat();

        apply_reset();
        check_reset_values("second reset values");
        drive_pairs(PAIRS);                               // 4 words too many
        if (overflow_o !== 1'b1) report_mismatch("overflow flag", 1, overflow_o);
        wait_startup("second startup delay");
        capture_frame("overflow run", 16);
        if (overflow_o !== 1'b1) report_mismatch("overflow sticky", 1, overflow_o);

        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
source/cam_video_pkg.sv
source/cam_byte_packer.sv
source/pixel_fifo.sv
source/video_timing_gen.sv
source/rgb_out_stage.sv
source/startup_ctrl.sv
source/cam_hdmi_top.sv
verif/tb_cam_hdmi_top.sv

// ==== Bender.yml ====
package:
  name: cam_hdmi

sources:
  - files:
      - source/cam_video_pkg.sv
      - source/cam_byte_packer.sv
      - source/pixel_fifo.sv
      - source/video_timing_gen.sv
      - source/rgb_out_stage.sv
      - source/startup_ctrl.sv
      - source/cam_hdmi_top.sv
  - target: test
    files:
      - verif/tb_cam_hdmi_top.sv
